//--- hdl/tpRamPkg.sv
/* Sizes, the two-way address view and the port payload types of the 2048x149 two-port RAM.
   Imported by the RTL modules of the subsystem and by its testbench */
`default_nettype none

package tpRamPkg;

    //==============================
    // Memory geometry
    //==============================
    localparam int MemDepth     = 2048;  // Words over both banks
    localparam int AddrWidth    = 11;    // Flat word index
    localparam int RowWidth     = 10;    // Row inside one bank
    localparam int DataWidth    = 149;   // Full word
    localparam int LoSliceWidth = 74;    // Low macro, bits 73:0
    localparam int HiSliceWidth = 75;    // High macro, bits 148:74

    typedef logic [DataWidth-1:0] ramData_t;  // One memory word

    //==============================
    // Address word
    //==============================
    // Bank bit sits on top so that the flat index runs bank0 first, then bank1
    typedef struct packed {
        logic                bank;  // 0 = rows 0..1023, 1 = rows 1024..2047
        logic [RowWidth-1:0] row;   // Row passed to all four macros
    } ramSplit_t;

    // Ports see the flat index, the banked wrapper sees bank and row
    typedef union packed {
        logic [AddrWidth-1:0] flat;   // Linear index from the host
        ramSplit_t            split;  // Bank decode view
    } ramAddr_t;

    //==============================
    // Port payloads
    //==============================
    typedef struct packed {
        ramAddr_t addr;  // Target word
        ramData_t data;  // Word to store
    } wrReq_t;

    typedef struct packed {
        ramAddr_t addr;  // Word to fetch
    } rdReq_t;

endpackage

`default_nettype wire

//--- hdl/tpRamMacro.sv
/* Behavioral model of one 1024-row two-port SRAM macro with active-low controls.
   Port A writes, port B reads into a register; instantiated per bank and slice */
`timescale 1ns/100ps
`default_nettype none

module tpRamMacro #(
    parameter int Width = tpRamPkg::LoSliceWidth  // Slice width, 74 or 75
) (
    input  wire logic                          ClkB,
    input  wire logic                          cenA,   // Write chip enable, low
    input  wire logic                          cenB,   // Read chip enable, low
    input  wire logic                          wenA,   // Write enable, low
    input  wire logic                          renB,   // Read enable, low
    input  wire logic [tpRamPkg::RowWidth-1:0] addrA,  // Write row
    input  wire logic [tpRamPkg::RowWidth-1:0] addrB,  // Read row
    input  wire logic [Width-1:0]              din,
    output logic      [Width-1:0]              q       // Registered read data
);
    import tpRamPkg::*;

    localparam int Rows = MemDepth / 2;  // One bank

    logic [Width-1:0] mem [Rows];  // Storage, no reset

    //==============================
    // Write port
    //==============================
    always_ff @(posedge ClkB) begin
        if (!cenA && !wenA) begin
            mem[addrA] <= din;  // Lands after this edge
        end
    end

    //==============================
    // Read port
    //==============================
    // Nonblocking read of the old row, so a same-edge write is not seen here
    always_ff @(posedge ClkB) begin
        if (!cenB && !renB) begin
            q <= mem[addrB];  // Holds when idle
        end
    end

    // Selected rows must be resolvable when the macro is enabled
    addrAKnown: assert property (@(posedge ClkB) (!cenA && !wenA) |-> !$isunknown(addrA))
        else $error("Macro write row unknown while enabled");

    addrBKnown: assert property (@(posedge ClkB) (!cenB && !renB) |-> !$isunknown(addrB))
        else $error("Macro read row unknown while enabled");

endmodule

`default_nettype wire

//--- hdl/tpRam2048x149.sv
/* Banked 2048x149 two-port RAM built from four 1024-row macros in two banks of two slices.
   Read data reaches q one cycle after rdEn through a delayed bank select */
`timescale 1ns/100ps
`default_nettype none

module tpRam2048x149 (
    input  wire logic               ClkB,
    input  wire logic               wrEn,    // One-cycle write strobe
    input  wire tpRamPkg::ramAddr_t wrAddr,
    input  wire tpRamPkg::ramData_t wrData,
    input  wire logic               rdEn,    // One-cycle read strobe
    input  wire tpRamPkg::ramAddr_t rdAddr,
    output tpRamPkg::ramData_t      q        // Valid the cycle after rdEn
);
    import tpRamPkg::*;

    logic [1:0]              wrCenN;     // Active-low write select per bank
    logic [1:0]              rdCenN;     // Active-low read select per bank
    logic                    wenN;       // Active-low shared write enable
    logic                    renN;       // Active-low shared read enable
    logic [LoSliceWidth-1:0] loQ [2];    // Low slice result per bank
    logic [HiSliceWidth-1:0] hiQ [2];    // High slice result per bank
    logic                    rdBankDly;  // Bank of the last read

    //==============================
    // Bank decode
    //==============================
    // Only the addressed bank sees its chip enable low
    assign wrCenN = {~wrAddr.split.bank, wrAddr.split.bank};
    assign rdCenN = {~rdAddr.split.bank, rdAddr.split.bank};
    assign wenN   = ~wrEn;
    assign renN   = ~rdEn;

    //==============================
    // Output steering
    //==============================
    // Macro output is registered, so the select trails the read by one cycle too
    always_ff @(posedge ClkB) begin
        if (rdEn) begin
            rdBankDly <= rdAddr.split.bank;  // Steers q on the next cycle
        end
    end

    assign q = rdBankDly ? {hiQ[1], loQ[1]} : {hiQ[0], loQ[0]};

    //==============================
    // Macro array
    //==============================
    for (genvar b = 0; b < 2; b++) begin : genBank
        tpRamMacro #(.Width(LoSliceWidth)) loSlice_i (  // Bits 73:0
            .ClkB  (ClkB),
            .cenA  (wrCenN[b]),
            .cenB  (rdCenN[b]),
            .wenA  (wenN),
            .renB  (renN),
            .addrA (wrAddr.split.row),
            .addrB (rdAddr.split.row),
            .din   (wrData[LoSliceWidth-1:0]),
            .q     (loQ[b])
        );

        tpRamMacro #(.Width(HiSliceWidth)) hiSlice_i (  // Bits 148:74
            .ClkB  (ClkB),
            .cenA  (wrCenN[b]),
            .cenB  (rdCenN[b]),
            .wenA  (wenN),
            .renB  (renN),
            .addrA (wrAddr.split.row),
            .addrB (rdAddr.split.row),
            .din   (wrData[LoSliceWidth +: HiSliceWidth]),
            .q     (hiQ[b])
        );
    end

    // Once the ports leave reset their strobes stay resolved
    enKnown: assert property (@(posedge ClkB)
        !$isunknown({wrEn, rdEn}) |=> !$isunknown({wrEn, rdEn}))
        else $error("Port strobe went unknown after reset");

endmodule

`default_nettype wire

//--- hdl/ramWritePort.sv
/* Four-phase req/ack write port for the banked RAM.
   Each accepted request gives exactly one registered write strobe */
`timescale 1ns/100ps
`default_nettype none

module ramWritePort (
    input  wire logic             ClkB,
    input  wire logic             reset,
    input  wire tpRamPkg::wrReq_t req,       // Payload, stable while reqValid
    input  wire logic             reqValid,  // Host req line
    output logic                  ack,       // Port ack line
    output logic                  wrEn,      // One cycle per request
    output tpRamPkg::ramAddr_t    wrAddr,
    output tpRamPkg::ramData_t    wrData
);

    typedef enum logic [1:0] {
        WrIdle,     // Waiting for req
        WrStrobe,   // wrEn high this cycle
        WrRelease   // ack high until req drops
    } wrState_e;

    wrState_e state;

    //==============================
    // Handshake FSM
    //==============================
    always_ff @(posedge ClkB) begin
        if (reset) begin
            state <= WrIdle;
            ack   <= 1'b0;
            wrEn  <= 1'b0;
        end else begin
            case (state)
                WrIdle: begin
                    if (reqValid) begin  // ack is low here
                        wrEn  <= 1'b1;
                        state <= WrStrobe;
                    end
                end
                WrStrobe: begin
                    wrEn  <= 1'b0;  // Macros capture on this edge
                    ack   <= 1'b1;
                    state <= WrRelease;
                end
                WrRelease: begin
                    if (!reqValid) begin  // Held req gets no new write
                        ack   <= 1'b0;
                        state <= WrIdle;
                    end
                end
                default: state <= WrIdle;
            endcase
        end
    end

    // Payload taken together with the strobe
    always_ff @(posedge ClkB) begin
        if (state == WrIdle && reqValid) begin
            wrAddr <= req.addr;
            wrData <= req.data;
        end
    end

    // Host must still be requesting when the port answers
    ackOnReq: assert property (@(posedge ClkB) disable iff (reset) $rose(ack) |-> reqValid)
        else $error("Write ack rose without a pending request");

endmodule

`default_nettype wire

//--- hdl/ramReadPort.sv
/* Four-phase req/ack read port for the banked RAM.
   Issues one read strobe, then captures the returned word two edges later */
`timescale 1ns/100ps
`default_nettype none

module ramReadPort (
    input  wire logic             ClkB,
    input  wire logic             reset,
    input  wire tpRamPkg::rdReq_t req,       // Payload, stable while reqValid
    input  wire logic             reqValid,  // Host req line
    output logic                  ack,       // Port ack line
    output tpRamPkg::ramData_t    rdData,    // Valid while ack is high
    output logic                  rdEn,      // One cycle per request
    output tpRamPkg::ramAddr_t    rdAddr,
    input  wire tpRamPkg::ramData_t q         // Wrapper read data
);

    typedef enum logic [1:0] {
        RdIdle,     // Waiting for req
        RdIssue,    // rdEn high, macros read on this edge
        RdCapture,  // q valid, loaded on this edge
        RdRelease   // ack high until req drops
    } rdState_e;

    rdState_e state;

    //==============================
    // Handshake FSM
    //==============================
    always_ff @(posedge ClkB) begin
        if (reset) begin
            state  <= RdIdle;
            ack    <= 1'b0;
            rdEn   <= 1'b0;
            rdData <= '0;
        end else begin
            case (state)
                RdIdle: begin
                    if (reqValid) begin  // Edge 0
                        rdEn  <= 1'b1;
                        state <= RdIssue;
                    end
                end
                RdIssue: begin
                    rdEn  <= 1'b0;  // Edge 1, macro q and bank select update
                    state <= RdCapture;
                end
                RdCapture: begin
                    rdData <= q;  // Edge 2
                    ack    <= 1'b1;
                    state  <= RdRelease;
                end
                RdRelease: begin
                    if (!reqValid) begin  // rdData kept until next read
                        ack   <= 1'b0;
                        state <= RdIdle;
                    end
                end
                default: state <= RdIdle;
            endcase
        end
    end

    // Read address registered with the strobe
    always_ff @(posedge ClkB) begin
        if (state == RdIdle && reqValid) begin
            rdAddr <= req.addr;
        end
    end

    // A high ack always answers a request seen one edge earlier
    ackFollowsReq: assert property (@(posedge ClkB) disable iff (reset)
        ack |-> $past(reqValid))
        else $error("Read ack high without a prior request");

endmodule

`default_nettype wire

//--- hdl/ramSubsys.sv
/* Two-port RAM subsystem top.
   Ties the write and read handshake ports to the banked 2048x149 array */
`timescale 1ns/100ps
`default_nettype none

module ramSubsys (
    input  wire logic             ClkB,
    input  wire logic             reset,
    input  wire tpRamPkg::wrReq_t wrReq,
    input  wire logic             wrReqValid,
    output logic                  wrAck,
    input  wire tpRamPkg::rdReq_t rdReq,
    input  wire logic             rdReqValid,
    output logic                  rdAck,
    output tpRamPkg::ramData_t    rdData
);
    import tpRamPkg::*;

    logic     wrEn;    // Write strobe to array
    ramAddr_t wrAddr;
    ramData_t wrData;
    logic     rdEn;    // Read strobe to array
    ramAddr_t rdAddr;
    ramData_t q;       // Array read data

    //==============================
    // Host ports
    //==============================
    ramWritePort writePort_i (
        .ClkB     (ClkB),
        .reset    (reset),
        .req      (wrReq),
        .reqValid (wrReqValid),
        .ack      (wrAck),
        .wrEn     (wrEn),
        .wrAddr   (wrAddr),
        .wrData   (wrData)
    );

    ramReadPort readPort_i (
        .ClkB     (ClkB),
        .reset    (reset),
        .req      (rdReq),
        .reqValid (rdReqValid),
        .ack      (rdAck),
        .rdData   (rdData),
        .rdEn     (rdEn),
        .rdAddr   (rdAddr),
        .q        (q)
    );

    //==============================
    // Banked array
    //==============================
    tpRam2048x149 ram_i (
        .ClkB   (ClkB),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData),
        .rdEn   (rdEn),
        .rdAddr (rdAddr),
        .q      (q)
    );

endmodule

`default_nettype wire

//--- sim/ramSubsysTb.sv
/* Directed testbench for the two-port RAM subsystem.
   Runs both four-phase ports against a shadow array and reports an error count */
`timescale 1ns/100ps
`default_nettype none

module ramSubsysTb;
    import tpRamPkg::*;

    localparam int HalfPeriod     = 50;    // 100 ns clock
    localparam int RandCount      = 200;   // Random writes, then as many reads
    localparam int WatchdogCycles = 4000;  // All tests need roughly 2400 cycles

    logic     ClkB;
    logic     reset;
    wrReq_t   wrReq;
    logic     wrReqValid;
    logic     wrAck;
    rdReq_t   rdReq;
    logic     rdReqValid;
    logic     rdAck;
    ramData_t rdData;

    ramData_t    shadow [MemDepth];  // Reference contents
    int unsigned wrList [$];         // Addresses written so far
    integer      seed;
    int          errors;
    int          checks;

    ramSubsys dut_i (
        .ClkB       (ClkB),
        .reset      (reset),
        .wrReq      (wrReq),
        .wrReqValid (wrReqValid),
        .wrAck      (wrAck),
        .rdReq      (rdReq),
        .rdReqValid (rdReqValid),
        .rdAck      (rdAck),
        .rdData     (rdData)
    );

    //==============================
    // Clock and watchdog
    //==============================
    initial begin
        ClkB = 1'b0;
        forever #HalfPeriod ClkB = ~ClkB;
    end

    initial begin
        repeat (WatchdogCycles) @(posedge ClkB);
        $display("Timeout after %0d cycles, a handshake ack never arrived", WatchdogCycles);
        $display("TEST FAILED");
        $finish;
    end

    //==============================
    // Checks and stimulus helpers
    //==============================
    task automatic checkWord(input string sigName, input ramData_t got, input ramData_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s got %h expected %h", $time, sigName, got, exp);
        end
    endtask

    task automatic checkBit(input string sigName, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s got %b expected %b", $time, sigName, got, exp);
        end
    endtask

    function automatic ramData_t randWord();
        ramData_t w;
        for (int i = 0; i < 5; i++) begin
            w = {w[DataWidth-33:0], $random(seed)};  // 160 bits shifted in
        end
        return w;
    endfunction

    function automatic int unsigned randAddr();
        return $unsigned($random(seed)) % MemDepth;
    endfunction

    // Full write handshake, holdCycles keeps req high after ack
    task automatic doWrite(input int unsigned addr, input ramData_t data, input int holdCycles);
        @(posedge ClkB);
        wrReq.addr.flat <= addr[AddrWidth-1:0];
        wrReq.data      <= data;
        wrReqValid      <= 1'b1;
        do @(negedge ClkB); while (!wrAck);
        shadow[addr] = data;
        wrList.push_back(addr);
        repeat (holdCycles) begin
            @(posedge ClkB);
            wrReq.data <= ~data;  // Must not reach memory
            @(negedge ClkB);
            checkBit("wrAck", wrAck, 1'b1);
        end
        @(posedge ClkB);
        wrReqValid <= 1'b0;
        do @(negedge ClkB); while (wrAck);
    endtask

    task automatic doRead(input int unsigned addr);
        @(posedge ClkB);
        rdReq.addr.flat <= addr[AddrWidth-1:0];
        rdReqValid      <= 1'b1;
        do @(negedge ClkB); while (!rdAck);
        checkWord($sformatf("rdData[%0d]", addr), rdData, shadow[addr]);
        @(posedge ClkB);
        rdReqValid <= 1'b0;
        do @(negedge ClkB); while (rdAck);
        checkWord($sformatf("rdData[%0d] held", addr), rdData, shadow[addr]);  // Kept after ack
    endtask

    // Both reqs raised on one edge, strobes meet at the macros on the same edge
    task automatic doWriteRead(input int unsigned wAddr, input ramData_t wData,
                               input int unsigned rAddr);
        ramData_t expRd;
        expRd = shadow[rAddr];  // Old word on a collision
        @(posedge ClkB);
        wrReq.addr.flat <= wAddr[AddrWidth-1:0];
        wrReq.data      <= wData;
        rdReq.addr.flat <= rAddr[AddrWidth-1:0];
        wrReqValid      <= 1'b1;
        rdReqValid      <= 1'b1;
        do @(negedge ClkB); while (!(wrAck && rdAck));
        checkWord($sformatf("rdData[%0d] concurrent", rAddr), rdData, expRd);
        shadow[wAddr] = wData;
        wrList.push_back(wAddr);
        @(posedge ClkB);
        wrReqValid <= 1'b0;
        rdReqValid <= 1'b0;
        do @(negedge ClkB); while (wrAck || rdAck);
    endtask

    //==============================
    // Directed tests
    //==============================
    task automatic testResetAndHold();
        checkBit("wrAck", wrAck, 1'b0);
        checkBit("rdAck", rdAck, 1'b0);
        checkWord("rdData", rdData, '0);  // Cleared by reset
        doWrite(37, randWord(), 4);
        doRead(37);  // First payload only
    endtask

    task automatic testBoundary();
        int unsigned addrs [4] = '{0, 1023, 1024, 2047};
        ramData_t    pat [4];
        pat[0] = {{HiSliceWidth{1'b0}}, {LoSliceWidth{1'b1}}};  // Bit 73 set, 74 clear
        pat[1] = {{HiSliceWidth{1'b1}}, {LoSliceWidth{1'b0}}};
        pat[2] = {{37{2'b10}}, 1'b1, {37{2'b01}}};
        pat[3] = {{37{2'b01}}, 1'b0, {37{2'b10}}};
        foreach (addrs[i]) begin
            doWrite(addrs[i], pat[i], 0);
        end
        foreach (addrs[i]) begin
            doRead(addrs[i]);
        end
    endtask

    task automatic testBankIsolation();
        int unsigned rows [3] = '{5, 512, 1000};
        foreach (rows[i]) begin
            doWrite(rows[i], randWord(), 0);
            doWrite(rows[i] + 1024, randWord(), 0);  // Same row, other bank
        end
        foreach (rows[i]) begin
            doRead(rows[i]);
            doRead(rows[i] + 1024);
        end
    endtask

    task automatic testRandom();
        repeat (RandCount) begin
            doWrite(randAddr(), randWord(), 0);
        end
        repeat (RandCount) begin
            doRead(wrList[$unsigned($random(seed)) % wrList.size()]);  // Known words only
        end
    endtask

    task automatic testConcurrent();
        doWrite(1500, randWord(), 0);
        doWriteRead(100, randWord(), 1500);   // Different addresses
        doRead(100);
        doWriteRead(1500, randWord(), 1500);  // Collision, old word back
        doRead(1500);                         // New word now stored
    endtask

    //==============================
    // Main sequence
    //==============================
    initial begin
        seed       = 32'h29ec;
        errors     = 0;
        checks     = 0;
        reset      = 1'b1;
        wrReq      = '0;
        wrReqValid = 1'b0;
        rdReq      = '0;
        rdReqValid = 1'b0;
        repeat (2) @(posedge ClkB);
        reset <= 1'b0;
        @(negedge ClkB);

        testResetAndHold();
        testBoundary();
        testBankIsolation();
        testRandom();
        testConcurrent();

        repeat (2) @(posedge ClkB);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
hdl/tpRamPkg.sv
hdl/tpRamMacro.sv
hdl/tpRam2048x149.sv
hdl/ramWritePort.sv
hdl/ramReadPort.sv
hdl/ramSubsys.sv
sim/ramSubsysTb.sv
